/* filelist.f */
design/types.sv
design/usb_tx.sv
design/usb_rx.sv
design/usb_crc16.sv
design/usb_link.sv
test/usb_link_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := usb_link_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := Result: PASSED

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* test/usb_link_tb.sv */
// ----------------------------------------------------------------------
// Loopback testbench for the USB low-speed link. Directed and random
// packets go out on D+/D- and come back through the receiver and CRC16.
// ----------------------------------------------------------------------
`default_nettype none

module usb_link_tb
   import types::*;
();

   typedef logic [7:0] byte_q_t [$];

   localparam int          TIMEOUT_CYCLES = 20000;    // 10 packets of 11 bytes, stuffed
   localparam int          GAP_CYCLES     = 64;       // idle J between packets
   localparam logic [15:0] USB_CRC16_POLY = 16'h8005;

   logic       clk;
   logic       reset;
   logic [7:0] data;
   logic       valid;
   logic       ready;
   d_port_t    d_o;
   logic       d_en;
   d_port_t    d_i;
   rx_byte_t   rx_byte;
   logic       rx_strobe;
   logic       rx_active;
   logic       rx_eop;
   logic       crc_ok;

   rx_byte_t   rx_q [$];   // bytes seen by the monitor
   int         eop_count;
   logic       crc_at_eop;
   int         cycle_count;
   int         checks;
   int         errors;
   integer     seed;

   usb_link u_dut (
      .clk       (clk),
      .reset     (reset),
      .data      (data),
      .valid     (valid),
      .ready     (ready),
      .d_o       (d_o),
      .d_en      (d_en),
      .d_i       (d_i),
      .rx_byte   (rx_byte),
      .rx_strobe (rx_strobe),
      .rx_active (rx_active),
      .rx_eop    (rx_eop),
      .crc_ok    (crc_ok)
   );

   always_comb
      if (d_en)
         d_i = d_o;  // loopback
      else
         d_i = J;    // idle pull

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial
   begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $finish;
   end

   // receive monitor sampling between edges
   always @(negedge clk)
      if (!reset)
      begin
         if (rx_strobe)
            rx_q.push_back(rx_byte);
         if (rx_eop)
         begin
            eop_count++;
            crc_at_eop = crc_ok;
         end
      end

   // the two USB CRC16 bytes to append to a payload
   function automatic byte_q_t crc16_bytes(input byte_q_t payload);
      logic [15:0] crc;
      logic [15:0] inv;
      logic [7:0]  lo;
      logic [7:0]  hi;
      logic        fb;
      byte_q_t     out;
      int          n;
      int          i;
      crc = 16'hFFFF;
      for (n = 0; n < payload.size(); n++)
         for (i = 0; i < 8; i++)
         begin
            fb  = crc[15] ^ payload[n][i];  // byte lsb goes out first
            crc = {crc[14:0], 1'b0};
            if (fb)
               crc = crc ^ USB_CRC16_POLY;
         end
      inv = ~crc;
      for (i = 0; i < 8; i++)
      begin
         lo[i] = inv[15 - i];  // remainder msb is the first CRC bit on the wire
         hi[i] = inv[7 - i];
      end
      out.push_back(lo);
      out.push_back(hi);
      return out;
   endfunction

   task automatic check_rx_byte(input rx_byte_t got, input rx_byte_t exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Error at %0t: %s got data %02h first %0b, expected data %02h first %0b",
                  $time, what, got.data, got.first, exp.data, exp.first);
      end
   endtask

   task automatic check_line(input d_port_t got, input d_port_t exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Error at %0t: %s got %s, expected %s", $time, what, got.name(), exp.name());
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Error at %0t: %s got %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      checks++;
      if (got != exp)
      begin
         errors++;
         $display("Error at %0t: %s got %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   // one packet out and back, with ready, EOP, idle and byte checks
   task automatic run_packet(input byte_q_t pkt, input string name);
      int       pulses;
      int       eop_base;
      int       i;
      rx_byte_t exp;
      rx_q.delete();
      eop_base = eop_count;
      pulses   = 0;
      @(posedge clk);
      data  <= pkt[0];
      valid <= 1'b1;
      while (pulses <= pkt.size())
      begin
         @(negedge clk);
         if (ready)
         begin
            pulses++;
            @(posedge clk);
            if (pulses < pkt.size())
               data <= pkt[pulses];
            else if (pulses > pkt.size())
               valid <= 1'b0;  // pulse n ends the packet
         end
      end
      while (d_en)
      begin
         @(negedge clk);
         if (ready)
            pulses++;
      end
      check_count(pulses, pkt.size() + 1, {name, " ready pulses"});
      check_line(d_o, J, {name, " line after d_en fall"});
      while (eop_count == eop_base)
         @(negedge clk);
      repeat (GAP_CYCLES) @(negedge clk);
      check_count(eop_count - eop_base, 1, {name, " rx_eop pulses"});
      check_bit(rx_active, 1'b0, {name, " rx_active after packet"});
      check_count(rx_q.size(), pkt.size(), {name, " strobes"});
      for (i = 0; i < pkt.size() && i < rx_q.size(); i++)
      begin
         exp.data  = pkt[i];
         exp.first = (i == 0);
         check_rx_byte(rx_q[i], exp, $sformatf("%s byte %0d", name, i));
      end
   endtask

   task automatic reset_state();
      @(negedge clk);
      check_bit(d_en, 1'b0, "d_en after reset");
      check_bit(ready, 1'b0, "ready after reset");
      check_bit(rx_active, 1'b0, "rx_active after reset");
      check_bit(rx_eop, 1'b0, "rx_eop after reset");
      check_bit(crc_ok, 1'b0, "crc_ok after reset");
      check_line(d_o, J, "d_o after reset");
   endtask

   task automatic crc_packets();
      byte_q_t payload;
      byte_q_t crc;
      byte_q_t pkt;
      payload = '{8'h12, 8'hA7};
      crc     = crc16_bytes(payload);
      pkt     = '{8'hC3, payload[0], payload[1], crc[0], crc[1]};  // DATA0 PID first
      run_packet(pkt, "crc good");
      check_bit(crc_at_eop, 1'b1, "crc_ok with correct crc");
      pkt[4] = pkt[4] ^ 8'h04;
      run_packet(pkt, "crc bad");
      check_bit(crc_at_eop, 1'b0, "crc_ok with one crc bit flipped");
   endtask

   task automatic random_packets();
      byte_q_t pkt;
      int      len;
      int      p;
      int      i;
      for (p = 0; p < 5; p++)
      begin
         pkt.delete();
         len = 1 + int'({$random(seed)} % 8);
         for (i = 0; i < len; i++)
            pkt.push_back(8'($random(seed)));
         run_packet(pkt, $sformatf("random packet %0d", p));
      end
   endtask

   initial
   begin
      seed       = 83;
      checks     = 0;
      errors     = 0;
      eop_count  = 0;
      crc_at_eop = 1'b0;
      data       = 8'h00;
      valid      = 1'b0;
      reset      = 1'b1;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      reset_state();
      run_packet('{8'hA5, 8'h3C, 8'h01}, "three bytes");
      crc_packets();
      run_packet('{8'hFF, 8'hFF, 8'h7E}, "stuffing");
      random_packets();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* design/usb_link.sv */
// --------------------------------------------------------------------
// USB low-speed link top: sender, receiver and CRC16 checker.
// Transmit and receive pins are separate, loop them for a self test.
// --------------------------------------------------------------------
`default_nettype none

module usb_link
   import types::*;
(
   input  logic       clk,
   input  logic       reset,

   // transmit side
   input  logic [7:0] data,
   input  logic       valid,
   output logic       ready,
   output d_port_t    d_o,
   output logic       d_en,

   // receive side
   input  d_port_t    d_i,
   output rx_byte_t   rx_byte,
   output logic       rx_strobe,
   output logic       rx_active,
   output logic       rx_eop,
   output logic       crc_ok
);

   usb_tx u_tx (
      .clk   (clk),
      .reset (reset),
      .data  (data),
      .valid (valid),
      .ready (ready),
      .d_o   (d_o),
      .d_en  (d_en)
   );

   usb_rx u_rx (
      .clk       (clk),
      .reset     (reset),
      .d_i       (d_i),
      .rx_byte   (rx_byte),
      .rx_strobe (rx_strobe),
      .rx_active (rx_active),
      .rx_eop    (rx_eop)
   );

   usb_crc16 u_crc16 (
      .clk       (clk),
      .reset     (reset),
      .rx_byte   (rx_byte),
      .rx_strobe (rx_strobe),
      .crc_ok    (crc_ok)
   );

endmodule

`default_nettype wire

/* design/usb_crc16.sv */
// --------------------------------------------------------------------
// CRC16 check on received data packets, one byte per strobe.
// crc_ok is valid at EOP once the CRC bytes have gone through.
// --------------------------------------------------------------------
`default_nettype none

module usb_crc16
   import types::*;
(
   input  logic     clk,
   input  logic     reset,
   input  rx_byte_t rx_byte,
   input  logic     rx_strobe,
   output logic     crc_ok
);

   logic [15:0] crc;

   // eight serial steps, lsb first
   function automatic logic [15:0] crc16_update(input logic [15:0] crc_in,
                                                input logic [7:0]  data);
      logic [15:0] c;
      logic        fb;
      int          i;
      c = crc_in;
      for (i = 0; i < 8; i++)
      begin
         fb = c[0] ^ data[i];
         c  = c >> 1;
         if (fb)
            c = c ^ CRC16_POLY;
      end
      return c;
   endfunction

   always_ff @(posedge clk)
      if (reset)
         crc <= '1;
      else if (rx_strobe)
         crc <= rx_byte.first ? '1 : crc16_update(crc, rx_byte.data);  // PID skipped

   always_comb
      crc_ok = (crc == CRC16_RESIDUAL);

endmodule

`default_nettype wire

/* design/usb_rx.sv */
// --------------------------------------------------------------------
// USB low-speed receiver: finds SYNC, decodes NRZI, drops stuffed bits
// and strobes out bytes lsb first until a two-bit SE0 ends the packet.
// --------------------------------------------------------------------
`default_nettype none

module usb_rx
   import types::*;
(
   input  logic     clk,
   input  logic     reset,
   input  d_port_t  d_i,
   output rx_byte_t rx_byte,
   output logic     rx_strobe,  // one cycle per byte
   output logic     rx_active,  // SYNC seen, no EOP yet
   output logic     rx_eop      // end of packet pulse
);

   typedef enum logic {
      RX_IDLE,
      RX_DATA
   } rx_state_t;

   rx_state_t            rx_state;
   d_port_t              d_meta;
   d_port_t              d_sync;
   d_port_t              d_last;
   d_port_t              last_sample;  // previous J/K sample
   logic [BIT_CNT_W-1:0] phase;        // clocks since last edge
   logic [7:0]           sync_shift;
   logic [7:0]           sync_next;
   logic [7:0]           data_shift;
   logic [7:0]           data_next;
   logic [2:0]           ones;
   logic [2:0]           bit_count;
   logic                 first_pending;
   logic                 se0_seen;
   logic                 sample;
   logic                 is_jk;
   logic                 line_se0;
   logic                 transition;
   logic                 rx_bit;
   logic                 data_bit_en;

   always_ff @(posedge clk)
      if (reset)
      begin
         d_meta <= J;
         d_sync <= J;
         d_last <= J;
      end
      else
      begin
         d_meta <= d_i;
         d_sync <= d_meta;
         d_last <= d_sync;
      end

   always_comb
   begin
      is_jk       = (d_sync == J) || (d_sync == K);
      line_se0    = (d_sync == SE0);
      transition  = is_jk && (d_sync != d_last);
      sample      = (phase == BIT_CNT_W'(CLKS_PER_BIT / 2));  // mid bit
      rx_bit      = (d_sync == last_sample);                   // no change is a one
      sync_next   = {rx_bit, sync_shift[7:1]};
      data_next   = {rx_bit, data_shift[7:1]};
      data_bit_en = sample && is_jk && (rx_state == RX_DATA) && (ones != STUFF_LIMIT);
      rx_active   = (rx_state == RX_DATA);
   end

   // realign the bit phase on every J/K edge
   always_ff @(posedge clk)
      if (reset || transition)
         phase <= '0;
      else if (phase == BIT_CNT_W'(CLKS_PER_BIT - 1))
         phase <= '0;
      else
         phase <= phase + 1'b1;

   always_ff @(posedge clk)
      if (reset)
      begin
         rx_state      <= RX_IDLE;
         last_sample   <= J;
         sync_shift    <= '1;
         ones          <= 3'd0;
         bit_count     <= 3'd0;
         first_pending <= 1'b0;
         se0_seen      <= 1'b0;
         rx_strobe     <= 1'b0;
         rx_eop        <= 1'b0;
      end
      else
      begin
         rx_strobe <= 1'b0;
         rx_eop    <= 1'b0;
         if (sample && line_se0)
         begin
            se0_seen <= 1'b1;
            if (se0_seen && rx_state == RX_DATA)
            begin
               rx_eop      <= 1'b1;
               rx_state    <= RX_IDLE;
               sync_shift  <= '1;  // no stale zeros toward the next SYNC
               last_sample <= J;
            end
         end
         else if (sample && is_jk)
         begin
            se0_seen    <= 1'b0;
            last_sample <= d_sync;
            if (rx_state == RX_IDLE)
            begin
               sync_shift <= sync_next;
               if (sync_next == SYNC_PATTERN)
               begin
                  rx_state      <= RX_DATA;
                  ones          <= 3'd1;  // last SYNC bit starts the run
                  bit_count     <= 3'd0;
                  first_pending <= 1'b1;
               end
            end
            else if (ones == STUFF_LIMIT)
               ones <= 3'd0;  // stuffed zero
            else
            begin
               ones      <= rx_bit ? ones + 3'd1 : 3'd0;
               bit_count <= bit_count + 3'd1;
               if (bit_count == 3'd7)
               begin
                  rx_strobe     <= 1'b1;
                  first_pending <= 1'b0;
               end
            end
         end
      end

   always_ff @(posedge clk)
      if (data_bit_en)
      begin
         data_shift <= data_next;
         if (bit_count == 3'd7)
         begin
            rx_byte.data  <= data_next;
            rx_byte.first <= first_pending;
         end
      end

endmodule

`default_nettype wire

/* design/usb_tx.sv */
// --------------------------------------------------------------------
// USB low-speed sender: SYNC, bit stuffing, NRZI and EOP on D+/D-.
// A rise of valid starts a packet, each ready pulse takes one byte.
// --------------------------------------------------------------------
`default_nettype none

module usb_tx
   import types::*;
(
   input  logic       clk,    // 24 MHz
   input  logic       reset,
   input  logic [7:0] data,   // byte from the SIE
   input  logic       valid,  // rise starts SYNC, fall ends packet
   output logic       ready,  // data taken
   output d_port_t    d_o,
   output logic       d_en
);

   typedef enum logic [2:0] {
      TX_RESET,
      TX_WAIT,
      SEND_SYNC,
      TX_DATA_LOAD,
      TX_DATA_WAIT,
      SEND_EOP
   } tx_state_t;

   tx_state_t            tx_state;
   tx_state_t            tx_next;
   logic [BIT_CNT_W-1:0] clk_counter;  // clocks within a line bit
   logic [2:0]           bit_counter;  // bit of byte, or EOP bit
   logic [2:0]           num_ones;     // run of ones on the line
   logic [7:0]           tx_load;      // next byte
   logic [7:0]           tx_shift;     // byte on the wire
   logic                 nrzi;         // 1 drives K
   logic                 active;
   logic                 data_phase;
   logic                 en_bit;
   logic                 stuffing;
   logic                 tx_serial;
   logic                 last_bit;
   logic                 eop_start;
   logic                 send_bit;

   always_comb
   begin
      active     = (tx_state != TX_RESET) && (tx_state != TX_WAIT);
      data_phase = (tx_state == SEND_SYNC) || (tx_state == TX_DATA_LOAD) ||
                   (tx_state == TX_DATA_WAIT);
      en_bit     = active && (clk_counter == '0);
      stuffing   = (num_ones == STUFF_LIMIT);
      tx_serial  = stuffing ? 1'b0 : tx_shift[0];
      ready      = en_bit && !stuffing && (bit_counter == 3'd6) &&
                   ((tx_state == SEND_SYNC) || (tx_state == TX_DATA_WAIT));
      last_bit   = en_bit && !stuffing && (tx_state == TX_DATA_LOAD) &&
                   (bit_counter == 3'd7);
      eop_start  = en_bit && !stuffing && (tx_state == TX_DATA_LOAD) &&
                   (bit_counter == 3'd0);  // only reached once valid is gone
      send_bit   = en_bit && data_phase && !eop_start;
      d_en       = active;
   end

   always_ff @(posedge clk)
      if (reset || !active)
         clk_counter <= '0;
      else if (clk_counter == BIT_CNT_W'(CLKS_PER_BIT - 1))
         clk_counter <= '0;
      else
         clk_counter <= clk_counter + 1'b1;

   always_ff @(posedge clk)
      if (reset || !active)
         bit_counter <= 3'd0;
      else if (eop_start)
         bit_counter <= 3'd0;
      else if (send_bit && !stuffing)
         bit_counter <= bit_counter + 3'd1;  // wraps at byte end
      else if (en_bit && tx_state == SEND_EOP)
         bit_counter <= bit_counter + 3'd1;

   always_ff @(posedge clk)
      if (reset)
         tx_state <= TX_RESET;
      else
         tx_state <= tx_next;

   always_comb
   begin
      tx_next = tx_state;
      case (tx_state)
         TX_RESET:
            tx_next = TX_WAIT;
         TX_WAIT:
            if (valid)
               tx_next = SEND_SYNC;
         SEND_SYNC:
            if (ready)
               tx_next = TX_DATA_LOAD;
         TX_DATA_LOAD:
            if (last_bit && valid)
               tx_next = TX_DATA_WAIT;
            else if (eop_start)
               tx_next = SEND_EOP;
         TX_DATA_WAIT:
            if (ready)
               tx_next = TX_DATA_LOAD;
         SEND_EOP:
            if (en_bit && bit_counter == 3'd2)
               tx_next = TX_WAIT;
         default:
            tx_next = TX_RESET;
      endcase
   end

   always_ff @(posedge clk)
      if (ready)
         tx_load <= data;

   always_ff @(posedge clk)
      if (tx_state == TX_WAIT && valid)
         tx_shift <= SYNC_PATTERN;
      else if (send_bit && !stuffing)
      begin
         if (last_bit)
            tx_shift <= tx_load;
         else
            tx_shift <= {1'b0, tx_shift[7:1]};
      end

   always_ff @(posedge clk)
      if (reset || !active)
         num_ones <= 3'd0;
      else if (send_bit)
         num_ones <= tx_serial ? num_ones + 3'd1 : 3'd0;

   // zero toggles the line, one keeps it
   always_ff @(posedge clk)
      if (reset || !active)
         nrzi <= 1'b0;
      else if (send_bit && !tx_serial)
         nrzi <= ~nrzi;

   always_comb
      case (tx_state)
         SEND_SYNC, TX_DATA_LOAD, TX_DATA_WAIT:
            d_o = nrzi ? K : J;
         SEND_EOP:
            d_o = (bit_counter < 3'd2) ? SE0 : J;  // two bits SE0, one bit J
         default:
            d_o = J;
      endcase

endmodule

`default_nettype wire

/* design/types.sv */
// --------------------------------------------------------------------
// Shared line-state, received-byte and link constants for the USB
// low-speed engine; imported by every design file.
// --------------------------------------------------------------------
`default_nettype none

package types;

   // D+ then D-; low speed idles with D- high
   typedef enum logic [1:0] {
      SE0 = 2'b00,
      J   = 2'b01,  // idle state
      K   = 2'b10,
      SE1 = 2'b11   // illegal on the bus
   } d_port_t;

   typedef struct packed {
      logic [7:0] data;   // received byte
      logic       first;  // first byte after SYNC (PID)
   } rx_byte_t;

   localparam int          CLKS_PER_BIT   = 16;  // 24 MHz / 1.5 MHz
   localparam int          BIT_CNT_W      = $clog2(CLKS_PER_BIT);
   localparam logic [7:0]  SYNC_PATTERN   = 8'b10000000;  // lsb goes out first
   localparam int          STUFF_LIMIT    = 6;

   // 16'h8005 and 16'h800D, bit reversed for lsb-first shifting
   localparam logic [15:0] CRC16_POLY     = 16'hA001;
   localparam logic [15:0] CRC16_RESIDUAL = 16'hB001;

endpackage

`default_nettype wire
